// ==== verilog/fletcherPkg.sv ====
`default_nettype none

package fletcherPkg;

    // one data word, and each running sum
    localparam int HalfWidth = 16;
    // full checksum, also the host data bus
    localparam int SumWidth = 32;
    // register address
    localparam int AddrWidth = 3;

    // 2^16 - 1, reduction modulus for both sums
    localparam logic [HalfWidth-1:0] Modulus = 16'd65535;

    // host register map, 6 and 7 unmapped
    typedef enum logic [AddrWidth-1:0] {
        RegCtrl   = 3'd0,
        RegData   = 3'd1,
        RegResult = 3'd2,
        RegExpect = 3'd3,
        RegStatus = 3'd4,
        RegCount  = 3'd5
    } RegAddr;

    // four-phase handshake states of the register block
    typedef enum logic [1:0] {
        BusIdle    = 2'd0,
        BusAck     = 2'd1,
        BusRelease = 2'd2
    } BusState;

endpackage

`default_nettype wire

// ==== verilog/fletcherAccumulator.sv ====
`default_nettype none

module fletcherAccumulator (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                clear,
    input  wire logic                                wordValid,
    input  wire logic [fletcherPkg::HalfWidth-1:0]   word,
    output logic      [fletcherPkg::SumWidth-1:0]    checksum
);

    // running sums, each kept in 0..65534
    logic [fletcherPkg::HalfWidth-1:0] sumA;
    logic [fletcherPkg::HalfWidth-1:0] sumB;

    // strobe delayed by one cycle, drives the sum B update
    logic validDly;

    // next values of both sums
    logic [fletcherPkg::HalfWidth-1:0] nextA;
    logic [fletcherPkg::HalfWidth-1:0] nextB;

    // one's-complement add, then fold all-ones to zero
    // result is (lhs + rhs) mod 65535 for lhs already reduced
    function automatic logic [fletcherPkg::HalfWidth-1:0] reduceAdd(
        input logic [fletcherPkg::HalfWidth-1:0] lhs,
        input logic [fletcherPkg::HalfWidth-1:0] rhs
    );
        logic [fletcherPkg::HalfWidth:0]   rawSum;
        logic [fletcherPkg::HalfWidth-1:0] folded;
        logic [fletcherPkg::HalfWidth-1:0] carryIn;
        // plain add, carry lands in the top bit
        rawSum = {1'b0, lhs} + {1'b0, rhs};
        // end-around carry back into bit 0
        carryIn = {{(fletcherPkg::HalfWidth-1){1'b0}}, rawSum[fletcherPkg::HalfWidth]};
        // cannot carry again since lhs never exceeds 65534
        folded = rawSum[fletcherPkg::HalfWidth-1:0] + carryIn;
        // all ones is the second zero of one's complement
        if (folded == fletcherPkg::Modulus) begin
            return '0;
        end
        return folded;
    endfunction

    // sum A takes the incoming word
    assign nextA = reduceAdd(sumA, word);

    // sum B takes sum A after its update has landed
    assign nextB = reduceAdd(sumB, sumA);

    // sum A stage, updates on the edge that samples the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            sumA <= '0;
        end else if (clear) begin
            // clear wins over a word in the same cycle
            sumA <= '0;
        end else if (wordValid) begin
            sumA <= nextA;
        end
    end

    // sum B stage, one cycle behind sum A
    always_ff @(posedge clk) begin
        if (rst) begin
            validDly <= 1'b0;
            sumB     <= '0;
        end else if (clear) begin
            validDly <= 1'b0;
            sumB     <= '0;
        end else begin
            validDly <= wordValid;
            if (validDly) begin
                sumB <= nextB;
            end
        end
    end

    // B in the upper half, A in the lower
    // settled two cycles after the last strobe
    assign checksum = {sumB, sumA};

endmodule

`default_nettype wire

// ==== verilog/checksumRegs.sv ====
`default_nettype none

module checksumRegs (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                req,
    input  wire logic                                write,
    input  wire logic [fletcherPkg::AddrWidth-1:0]   addr,
    input  wire logic [fletcherPkg::SumWidth-1:0]    wdata,
    output logic                                     ack,
    output logic      [fletcherPkg::SumWidth-1:0]    rdata,
    input  wire logic [fletcherPkg::SumWidth-1:0]    checksum,
    output logic                                     wordValid,
    output logic      [fletcherPkg::HalfWidth-1:0]   word,
    output logic                                     clear
);

    // handshake state
    fletcherPkg::BusState busState;

    // decoded register select
    fletcherPkg::RegAddr regSel;

    // host-visible state
    logic [fletcherPkg::SumWidth-1:0] expectValue;
    logic [fletcherPkg::SumWidth-1:0] wordCount;

    // strobes held from the access edge until ack rises
    logic dataPend;
    logic clearPend;

    // decoded access kinds
    logic dataWrite;
    logic ctrlClear;
    logic expectWrite;

    // status bits
    logic countNonzero;
    logic matchFlag;

    // read mux output
    logic [fletcherPkg::SumWidth-1:0] readValue;

    assign regSel = fletcherPkg::RegAddr'(addr);

    // write decode, only meaningful while the access is taken
    assign dataWrite   = write && (regSel == fletcherPkg::RegData);
    assign ctrlClear   = write && (regSel == fletcherPkg::RegCtrl) && wdata[0];
    assign expectWrite = write && (regSel == fletcherPkg::RegExpect);

    // match needs at least one word
    // so a fresh engine never matches an expected value of zero
    assign countNonzero = |wordCount;
    assign matchFlag    = (checksum == expectValue) && countNonzero;

    // read mux
    // write-only and unmapped addresses return zero
    always_comb begin
        readValue = '0;
        case (regSel)
            fletcherPkg::RegResult: readValue = checksum;
            fletcherPkg::RegExpect: readValue = expectValue;
            fletcherPkg::RegStatus: begin
                readValue[0] = matchFlag;
                readValue[1] = countNonzero;
            end
            fletcherPkg::RegCount:  readValue = wordCount;
            default:                readValue = '0;
        endcase
    end

    // four-phase FSM
    // idle: req seen, access done once, go to ack
    // ack: raise ack and fire pending strobes
    // release: hold ack until host drops req
    always_ff @(posedge clk) begin
        if (rst) begin
            busState    <= fletcherPkg::BusIdle;
            ack         <= 1'b0;
            rdata       <= '0;
            expectValue <= '0;
            wordCount   <= '0;
            dataPend    <= 1'b0;
            clearPend   <= 1'b0;
            wordValid   <= 1'b0;
            clear       <= 1'b0;
        end else begin
            // strobes last a single cycle
            wordValid <= 1'b0;
            clear     <= 1'b0;
            case (busState)
                fletcherPkg::BusIdle: begin
                    if (req) begin
                        busState  <= fletcherPkg::BusAck;
                        dataPend  <= dataWrite;
                        clearPend <= ctrlClear;
                        // read data frozen here, stable through ack
                        if (!write) begin
                            rdata <= readValue;
                        end
                        if (expectWrite) begin
                            expectValue <= wdata;
                        end
                        if (ctrlClear) begin
                            wordCount <= '0;
                        end else if (dataWrite) begin
                            wordCount <= wordCount + 1'b1;
                        end
                    end
                end
                fletcherPkg::BusAck: begin
                    // word strobe leaves on the same edge as ack
                    ack       <= 1'b1;
                    wordValid <= dataPend;
                    clear     <= clearPend;
                    busState  <= fletcherPkg::BusRelease;
                end
                fletcherPkg::BusRelease: begin
                    if (!req) begin
                        ack      <= 1'b0;
                        busState <= fletcherPkg::BusIdle;
                    end
                end
                default: begin
                    ack      <= 1'b0;
                    busState <= fletcherPkg::BusIdle;
                end
            endcase
        end
    end

    // data word captured with the access, held for the strobe
    always_ff @(posedge clk) begin
        if ((busState == fletcherPkg::BusIdle) && req && dataWrite) begin
            word <= wdata[fletcherPkg::HalfWidth-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/checksumTop.sv ====
`default_nettype none

module checksumTop (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                req,
    input  wire logic                                write,
    input  wire logic [fletcherPkg::AddrWidth-1:0]   addr,
    input  wire logic [fletcherPkg::SumWidth-1:0]    wdata,
    output logic                                     ack,
    output logic      [fletcherPkg::SumWidth-1:0]    rdata
);

    // register block to accumulator
    logic                              wordValid;
    logic [fletcherPkg::HalfWidth-1:0] word;
    logic                              clear;

    // accumulator back to register block
    logic [fletcherPkg::SumWidth-1:0]  checksum;

    // host side, four-phase req/ack
    checksumRegs u_regs (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .write     (write),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .checksum  (checksum),
        .wordValid (wordValid),
        .word      (word),
        .clear     (clear)
    );

    // running sums, one word per cycle at most
    fletcherAccumulator u_accum (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .wordValid (wordValid),
        .word      (word),
        .checksum  (checksum)
    );

endmodule

`default_nettype wire

// ==== test/tbChecksum.sv ====
`default_nettype none

module tbChecksum;

    // rough transaction total over all tests, with some slack
    localparam int TxnBudget = 140;
    // each transaction stays well under 8 cycles of 20 units
    localparam int WatchdogLimit = TxnBudget * 8 * 20 + 2000;

    logic        clk;
    logic        rst;
    logic        req;
    logic        write;
    logic [2:0]  addr;
    logic [31:0] wdata;
    logic        ack;
    logic [31:0] rdata;

    // bookkeeping
    int errorCount;
    int passCount;
    int failCount;
    int testErrStart;
    int seed;

    // software Fletcher-32 state
    int modelA;
    int modelB;
    int modelCount;

    // handshake monitor history
    logic prevReq;
    logic prevAck;

    checksumTop u_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .write (write),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t signal %s expected %08h actual %08h",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // reference sums, each modulo 65535
    task automatic modelClear();
        modelA = 0;
        modelB = 0;
        modelCount = 0;
    endtask

    task automatic modelAdd(input logic [15:0] w);
        modelA = (modelA + int'(w)) % 65535;
        modelB = (modelB + modelA) % 65535;
        modelCount++;
    endtask

    function automatic logic [31:0] modelValue();
        return {modelB[15:0], modelA[15:0]};
    endfunction

    // bit 0 match with nonzero count, bit 1 count nonzero
    function automatic logic [31:0] expectedStatus(input logic [31:0] expectReg);
        logic [31:0] s;
        s = '0;
        s[1] = (modelCount != 0);
        s[0] = (modelValue() === expectReg) && (modelCount != 0);
        return s;
    endfunction

    // one full four-phase transaction
    // drive on rising edges, sample on falling edges
    task automatic busAccess(input logic w, input logic [2:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        @(posedge clk);
        req   <= 1'b1;
        write <= w;
        addr  <= a;
        wdata <= d;
        do @(negedge clk); while (!ack);
        rd = rdata;
        @(posedge clk);
        req <= 1'b0;
        // next request only once ack is seen low
        do @(negedge clk); while (ack);
    endtask

    task automatic writeReg(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] unused;
        busAccess(1'b1, a, d, unused);
    endtask

    task automatic readReg(input logic [2:0] a, output logic [31:0] rd);
        busAccess(1'b0, a, 32'h0, rd);
    endtask

    task automatic sendWord(input logic [15:0] w);
        writeReg(fletcherPkg::RegData, {16'h0, w});
        modelAdd(w);
    endtask

    task automatic clearEngine();
        writeReg(fletcherPkg::RegCtrl, 32'h1);
        modelClear();
    endtask

    task automatic sendRandom(input int n);
        int rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            sendWord(rnd[15:0]);
        end
    endtask

    task automatic beginTest();
        testErrStart = errorCount;
    endtask

    task automatic endTest(input string name);
        if (errorCount == testErrStart) begin
            passCount++;
            $display("test %-10s ok", name);
        end else begin
            failCount++;
            $display("test %-10s failed with %0d errors", name, errorCount - testErrStart);
        end
    endtask

    // four-phase rule, checked every cycle outside reset
    always @(negedge clk) begin
        if (!rst) begin
            if (ack && !prevAck) begin
                assert (prevReq) else begin
                    $display("ack rose at time %0t without a request", $time);
                    errorCount++;
                end
            end
            if (prevAck && prevReq) begin
                assert (ack) else begin
                    $display("ack dropped at time %0t while req was still high", $time);
                    errorCount++;
                end
            end
            if (prevAck && !ack) begin
                assert (!prevReq) else begin
                    $display("ack fell at time %0t before req dropped", $time);
                    errorCount++;
                end
            end
        end
        prevReq <= req;
        prevAck <= ack;
    end

    // hang guard sized from the transaction budget
    initial begin
        #(WatchdogLimit);
        $display("timeout: the bus handshake stalled before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] lowBefore;
        logic [31:0] expectReg;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        write = 1'b0;
        addr = 3'd0;
        wdata = 32'h0;
        prevReq = 1'b0;
        prevAck = 1'b0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        seed = 32'h961b_3dce;
        modelClear();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // reset values, unmapped space
        beginTest();
        checkValue("ack", {31'h0, ack}, 32'h0);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, 32'h0);
        readReg(fletcherPkg::RegCount, rd);
        checkValue("RegCount", rd, 32'h0);
        readReg(fletcherPkg::RegStatus, rd);
        checkValue("RegStatus", rd, 32'h0);
        readReg(3'd6, rd);
        checkValue("unmapped6", rd, 32'h0);
        writeReg(3'd7, 32'hdead_1234);
        readReg(3'd7, rd);
        checkValue("unmapped7", rd, 32'h0);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, 32'h0);
        readReg(fletcherPkg::RegCount, rd);
        checkValue("RegCount", rd, 32'h0);
        readReg(fletcherPkg::RegExpect, rd);
        checkValue("RegExpect", rd, 32'h0);
        endTest("reset");

        // one count step per data write
        beginTest();
        clearEngine();
        sendRandom(5);
        readReg(fletcherPkg::RegCount, rd);
        checkValue("RegCount", rd, 32'd5);
        endTest("handshake");

        // fixed list then random words
        beginTest();
        clearEngine();
        sendWord(16'h0001);
        sendWord(16'h0002);
        sendWord(16'habcd);
        sendWord(16'hffff);
        sendWord(16'h1234);
        sendRandom(64);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, modelValue());
        readReg(fletcherPkg::RegCount, rd);
        checkValue("RegCount", rd, modelCount);
        endTest("sequence");

        // 0xffff is zero mod 65535
        beginTest();
        clearEngine();
        sendWord(16'h1234);
        sendWord(16'h0100);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, modelValue());
        // model sum A before the all-ones words
        lowBefore = {16'h0, modelA[15:0]};
        sendWord(16'hffff);
        sendWord(16'hffff);
        sendWord(16'hffff);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("sumA", {16'h0, rd[15:0]}, lowBefore);
        checkValue("RegResult", rd, modelValue());
        // sum A lands exactly on 65535
        clearEngine();
        sendWord(16'h8000);
        sendWord(16'h7fff);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("sumA", {16'h0, rd[15:0]}, 32'h0);
        checkValue("RegResult", rd, modelValue());
        endTest("wrap");

        // clear, then a fresh run
        beginTest();
        sendRandom(3);
        clearEngine();
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, 32'h0);
        readReg(fletcherPkg::RegCount, rd);
        checkValue("RegCount", rd, 32'h0);
        sendRandom(8);
        readReg(fletcherPkg::RegResult, rd);
        checkValue("RegResult", rd, modelValue());
        endTest("clear");

        // status match and count bits
        beginTest();
        expectReg = modelValue();
        writeReg(fletcherPkg::RegExpect, expectReg);
        readReg(fletcherPkg::RegStatus, rd);
        checkValue("RegStatus", rd, expectedStatus(expectReg));
        checkValue("matchBit", {31'h0, rd[0]}, 32'h1);
        sendWord(16'h0001);
        readReg(fletcherPkg::RegStatus, rd);
        checkValue("RegStatus", rd, expectedStatus(expectReg));
        checkValue("matchBit", {31'h0, rd[0]}, 32'h0);
        clearEngine();
        readReg(fletcherPkg::RegStatus, rd);
        checkValue("RegStatus", rd, expectedStatus(expectReg));
        endTest("compare");

        $display("tests passed %0d, failed %0d, check errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/fletcherPkg.sv
verilog/fletcherAccumulator.sv
verilog/checksumRegs.sv
verilog/checksumTop.sv
test/tbChecksum.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbChecksum
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
